// ==== hifi_pkg.sv ====
package hifi_pkg;

   // Reorder RAM geometry.
   // Eight blocks of 512 bytes, 64-bit beats.
   localparam int BLOCK_COUNT = 8;
   localparam int BEATS_PER_BLOCK = 64;
   localparam int RAM_DEPTH = BLOCK_COUNT * BEATS_PER_BLOCK;

   // Shift from completed blocks to bytes.
   localparam int BYTES_PER_BLOCK_LOG2 = 9;

   // Channel number carried in the upper tag nibble.
   localparam logic [3:0] CHANNEL_ID = 4'd1;

   // Request throttling.
   // Two of the eight slots stay free as margin.
   localparam int MAX_OUTSTANDING = 6;
   localparam int HOLDOFF_CYCLES = 3;

   // Output FIFO sizing.
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
   // Free slots needed before the drain may issue a beat.
   localparam int FIFO_SPACE_MIN = 3;

   // Data and tag fields.
   typedef logic [63:0] beat_t;
   typedef logic [7:0] tag_t;
   typedef logic [5:0] beat_index_t;

   // Block pointers wrap modulo BLOCK_COUNT.
   typedef logic [2:0] block_ptr_t;
   // Block in the upper bits, beat in the lower bits.
   typedef logic [8:0] ram_addr_t;

   typedef logic [31:0] status_t;
   // Completed blocks, before the shift into bytes.
   typedef logic [$bits(status_t)-BYTES_PER_BLOCK_LOG2-1:0] block_count_t;

   typedef logic [$clog2(HOLDOFF_CYCLES+1)-1:0] holdoff_t;
   typedef logic [FIFO_PTR_BITS-1:0] fifo_ptr_t;
   // One extra bit so a full FIFO is distinct from empty.
   typedef logic [FIFO_PTR_BITS:0] fifo_count_t;

endpackage

// ==== block_ram.sv ====
module block_ram (
   input  logic                clock,
   // Write port.
   input  logic                i_w_valid,
   input  hifi_pkg::ram_addr_t i_w_addr,
   input  hifi_pkg::beat_t     i_w_data,
   // Read port, one cycle latency.
   input  hifi_pkg::ram_addr_t i_r_addr,
   output hifi_pkg::beat_t     o_r_data
);

   import hifi_pkg::*;

   // Storage for all reorder blocks.
   beat_t mem [RAM_DEPTH];

   // Write on strobe.
   always_ff @(posedge clock) begin
      if (i_w_valid) begin
         mem[i_w_addr] <= i_w_data;
      end
   end

   // Registered read.
   // Data for an address shows up the next cycle.
   always_ff @(posedge clock) begin
      o_r_data <= mem[i_r_addr];
   end

endmodule

// ==== read_request_scheduler.sv ====
module read_request_scheduler (
   input  logic                 clock,
   input  logic                 reset,
   // Accept strobe from the host, one cycle per request.
   input  logic                 i_rr_ready,
   // Block the drain is currently reading.
   input  hifi_pkg::block_ptr_t i_consumed_block,
   output logic                 o_rr_valid,
   output hifi_pkg::block_ptr_t o_rr_tag_low
);

   import hifi_pkg::*;

   // Next block to request.
   block_ptr_t request_block;
   // Quiet cycles left after an accept.
   holdoff_t   holdoff;
   // Blocks requested but not yet drained.
   block_ptr_t outstanding;
   logic       holdoff_idle;
   logic       room;

   // Distance between request and consumed pointers.
   // Modulo 8 arithmetic, never more than MAX_OUTSTANDING.
   assign outstanding = request_block - i_consumed_block;

   // Space for one more block in the reorder RAM.
   assign room = outstanding < block_ptr_t'(MAX_OUTSTANDING);

   assign holdoff_idle = (holdoff == '0);

   // Request while quiet and a slot is free.
   assign o_rr_valid = holdoff_idle && room;

   // Tag low bits name the reorder block.
   assign o_rr_tag_low = request_block;

   // Request pointer.
   // Moves on every accept.
   always_ff @(posedge clock) begin
      if (reset) begin
         request_block <= '0;
      end else if (i_rr_ready) begin
         request_block <= request_block + 1'b1;
      end
   end

   // Holdoff counter.
   // Loaded on accept, then counts down to zero.
   always_ff @(posedge clock) begin
      if (reset) begin
         holdoff <= '0;
      end else if (i_rr_ready) begin
         holdoff <= holdoff_t'(HOLDOFF_CYCLES);
      end else if (!holdoff_idle) begin
         holdoff <= holdoff - 1'b1;
      end
   end

endmodule

// ==== completion_reorder.sv ====
module completion_reorder (
   input  logic                  clock,
   input  logic                  reset,
   // Completion beats, no back-pressure.
   input  logic                  i_rc_valid,
   input  hifi_pkg::tag_t        i_rc_tag,
   input  hifi_pkg::beat_index_t i_rc_index,
   input  hifi_pkg::beat_t       i_rc_data,
   // Read side, driven by the drain.
   input  hifi_pkg::ram_addr_t   i_r_addr,
   output hifi_pkg::beat_t       o_r_data,
   // First block not yet committed.
   output hifi_pkg::block_ptr_t  o_commit_block,
   output hifi_pkg::status_t     o_status
);

   import hifi_pkg::*;

   logic                   own_beat;
   logic                   own_last;
   block_ptr_t             rc_block;
   ram_addr_t              w_addr;
   // One flag per block, set by its last beat.
   logic [BLOCK_COUNT-1:0] filled;
   block_ptr_t             commit_block;
   logic                   commit_step;
   block_count_t           block_count;

   // Channel decode on the upper tag nibble.
   assign own_beat = i_rc_valid && (i_rc_tag[7:4] == CHANNEL_ID);

   // Last beat of a block closes it.
   assign own_last = own_beat && (i_rc_index == beat_index_t'(BEATS_PER_BLOCK - 1));

   // Block number from the low tag bits.
   assign rc_block = i_rc_tag[2:0];
   assign w_addr = {rc_block, i_rc_index};

   // Head block complete, commit it.
   assign commit_step = filled[commit_block];

   block_ram u_block_ram (
      .clock     (clock),
      .i_w_valid (own_beat),
      .i_w_addr  (w_addr),
      .i_w_data  (i_rc_data),
      .i_r_addr  (i_r_addr),
      .o_r_data  (o_r_data)
   );

   // Filled flags.
   // Set wins over clear, a block is never both.
   always_ff @(posedge clock) begin
      if (reset) begin
         filled <= '0;
      end else begin
         for (int i = 0; i < BLOCK_COUNT; i++) begin
            if (own_last && (rc_block == block_ptr_t'(i))) begin
               filled[i] <= 1'b1;
            end else if (commit_step && (commit_block == block_ptr_t'(i))) begin
               filled[i] <= 1'b0;
            end
         end
      end
   end

   // Commit pointer, strictly in request order.
   // At most one block per cycle.
   always_ff @(posedge clock) begin
      if (reset) begin
         commit_block <= '0;
      end else if (commit_step) begin
         commit_block <= commit_block + 1'b1;
      end
   end

   // Completed block count for status.
   always_ff @(posedge clock) begin
      if (reset) begin
         block_count <= '0;
      end else if (own_last) begin
         block_count <= block_count + 1'b1;
      end
   end

   assign o_commit_block = commit_block;

   // Bytes received, whole blocks only.
   assign o_status = status_t'(block_count) << BYTES_PER_BLOCK_LOG2;

endmodule

// ==== reorder_drain.sv ====
module reorder_drain (
   input  logic                 clock,
   input  logic                 reset,
   // First block not yet committed by the reorder buffer.
   input  hifi_pkg::block_ptr_t i_commit_block,
   // FIFO has room for the beats in flight.
   input  logic                 i_fifo_space,
   output hifi_pkg::ram_addr_t  o_r_addr,
   output logic                 o_fifo_write,
   output hifi_pkg::block_ptr_t o_consumed_block
);

   import hifi_pkg::*;

   // Beat read pointer over the whole RAM.
   ram_addr_t  read_addr;
   block_ptr_t read_block;
   logic       block_ready;
   logic       read_step;
   // Write strobe, aligned with the RAM output.
   logic       write_q;

   // Block part of the read pointer.
   assign read_block = read_addr[$bits(ram_addr_t)-1 -: $bits(block_ptr_t)];

   // Reading block is committed while it trails the commit pointer.
   assign block_ready = (read_block != i_commit_block);

   // One beat per cycle while data and space allow.
   // Stalls with nothing lost under back-pressure.
   assign read_step = block_ready && i_fifo_space;

   // Read pointer.
   // Wraps from the last beat of block 7 to block 0.
   always_ff @(posedge clock) begin
      if (reset) begin
         read_addr <= '0;
      end else if (read_step) begin
         read_addr <= read_addr + 1'b1;
      end
   end

   // Strobe follows the address by one cycle.
   // Matches the registered RAM read.
   always_ff @(posedge clock) begin
      if (reset) begin
         write_q <= 1'b0;
      end else begin
         write_q <= read_step;
      end
   end

   assign o_r_addr = read_addr;
   assign o_fifo_write = write_q;

   // Block being read still counts as outstanding.
   assign o_consumed_block = read_block;

endmodule

// ==== fwft_fifo.sv ====
module fwft_fifo (
   input  logic            clock,
   input  logic            reset,
   // Write side.
   input  logic            i_write,
   input  hifi_pkg::beat_t i_data,
   // Read side, head shown before the read.
   input  logic            i_read,
   output hifi_pkg::beat_t o_data,
   output logic            o_valid,
   // Enough free slots for the beats in flight.
   output logic            o_space
);

   import hifi_pkg::*;

   beat_t       mem [FIFO_DEPTH];
   fifo_ptr_t   wr_ptr;
   fifo_ptr_t   rd_ptr;
   fifo_count_t count;
   logic        full;
   logic        do_write;
   logic        do_read;

   assign full = (count == fifo_count_t'(FIFO_DEPTH));

   // Pop only a valid head.
   assign do_read = i_read && o_valid;

   // Overflow guard, the space flag keeps this from firing.
   assign do_write = i_write && !full;

   // Storage.
   always_ff @(posedge clock) begin
      if (do_write) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // Pointers wrap with the power of two depth.
   always_ff @(posedge clock) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Fill level.
   always_ff @(posedge clock) begin
      if (reset) begin
         count <= '0;
      end else if (do_write && !do_read) begin
         count <= count + 1'b1;
      end else if (do_read && !do_write) begin
         count <= count - 1'b1;
      end
   end

   // Head presented combinationally.
   assign o_data = mem[rd_ptr];
   assign o_valid = (count != '0);

   // At least FIFO_SPACE_MIN slots free.
   assign o_space = (count <= fifo_count_t'(FIFO_DEPTH - FIFO_SPACE_MIN));

endmodule

// ==== host_read_channel.sv ====
module host_read_channel (
   input  logic                  clock,
   input  logic                  reset,
   // Read requests, host pulses ready to accept.
   output logic                  o_rr_valid,
   output hifi_pkg::block_ptr_t  o_rr_tag_low,
   input  logic                  i_rr_ready,
   // Read completions, one strobe per beat.
   input  logic                  i_rc_valid,
   input  hifi_pkg::tag_t        i_rc_tag,
   input  hifi_pkg::beat_index_t i_rc_index,
   input  hifi_pkg::beat_t       i_rc_data,
   // Byte count of completed blocks.
   output hifi_pkg::status_t     o_status,
   // Output stream to user logic.
   input  logic                  i_fifo_read,
   output hifi_pkg::beat_t       o_fifo_data,
   output logic                  o_fifo_valid
);

   import hifi_pkg::*;

   block_ptr_t commit_block;
   block_ptr_t consumed_block;
   ram_addr_t  r_addr;
   beat_t      r_data;
   logic       fifo_space;
   logic       fifo_write;

   // Request side, throttled by drained blocks.
   read_request_scheduler u_scheduler (
      .clock            (clock),
      .reset            (reset),
      .i_rr_ready       (i_rr_ready),
      .i_consumed_block (consumed_block),
      .o_rr_valid       (o_rr_valid),
      .o_rr_tag_low     (o_rr_tag_low)
   );

   // Completion side, reorders into the RAM.
   completion_reorder u_reorder (
      .clock          (clock),
      .reset          (reset),
      .i_rc_valid     (i_rc_valid),
      .i_rc_tag       (i_rc_tag),
      .i_rc_index     (i_rc_index),
      .i_rc_data      (i_rc_data),
      .i_r_addr       (r_addr),
      .o_r_data       (r_data),
      .o_commit_block (commit_block),
      .o_status       (o_status)
   );

   // Moves committed blocks into the FIFO.
   reorder_drain u_drain (
      .clock            (clock),
      .reset            (reset),
      .i_commit_block   (commit_block),
      .i_fifo_space     (fifo_space),
      .o_r_addr         (r_addr),
      .o_fifo_write     (fifo_write),
      .o_consumed_block (consumed_block)
   );

   // RAM read data feeds the FIFO directly.
   fwft_fifo u_fifo (
      .clock   (clock),
      .reset   (reset),
      .i_write (fifo_write),
      .i_data  (r_data),
      .i_read  (i_fifo_read),
      .o_data  (o_fifo_data),
      .o_valid (o_fifo_valid),
      .o_space (fifo_space)
   );

endmodule

// ==== tb_host_read_channel.sv ====
module tb_host_read_channel;

   import hifi_pkg::*;

   // Run length and limits.
   localparam int NUM_BLOCKS = 40;
   localparam int TOTAL_BEATS = NUM_BLOCKS * BEATS_PER_BLOCK;
   localparam int RUN_LIMIT = 40000;
   localparam int TAIL_CYCLES = 60;

   logic        clock;
   logic        reset;
   logic        o_rr_valid;
   block_ptr_t  o_rr_tag_low;
   logic        i_rr_ready;
   logic        i_rc_valid;
   tag_t        i_rc_tag;
   beat_index_t i_rc_index;
   beat_t       i_rc_data;
   status_t     o_status;
   logic        i_fifo_read;
   beat_t       o_fifo_data;
   logic        o_fifo_valid;

   logic [31:0] rng_state;
   // Host model with one slot per reorder block.
   logic        slot_busy [BLOCK_COUNT];
   int          slot_seq [BLOCK_COUNT];
   // Beats 0 to 62 not yet returned.
   // The last beat always goes last.
   int          rem_cnt [BLOCK_COUNT];
   beat_index_t rem_idx [BLOCK_COUNT][BEATS_PER_BLOCK];
   int          accepted;
   int          last_sent;
   // Also the value of the next expected beat.
   int          beats_read;
   int          quiet_left;
   int          cycles;

   host_read_channel dut (
      .clock        (clock),
      .reset        (reset),
      .o_rr_valid   (o_rr_valid),
      .o_rr_tag_low (o_rr_tag_low),
      .i_rr_ready   (i_rr_ready),
      .i_rc_valid   (i_rc_valid),
      .i_rc_tag     (i_rc_tag),
      .i_rc_index   (i_rc_index),
      .i_rc_data    (i_rc_data),
      .o_status     (o_status),
      .i_fifo_read  (i_fifo_read),
      .o_fifo_data  (o_fifo_data),
      .o_fifo_valid (o_fifo_valid)
   );

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   task automatic abort_run();
      $display("Something failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic fail_value(input string test, input int expected, input int actual);
      $display("FAILED %s: expected %0d, actual %0d", test, expected, actual);
      abort_run();
   endtask

   // 32-bit xorshift step.
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function int next_random();
      rng_state = xorshift(rng_state);
      return int'({1'b0, rng_state[30:0]});
   endfunction

   // Holdoff seen one cycle after every accept.
   holdoff_after_accept: assert property (@(posedge clock) disable iff (reset)
      i_rr_ready |=> !o_rr_valid)
      else fail_value("holdoff_after_accept", 0, 1);

   task automatic check_outputs();
      int pending;
      pending = 0;
      for (int s = 0; s < BLOCK_COUNT; s++) begin
         if (slot_busy[s]) pending++;
      end
      // Own last beats seen so far.
      // Each one adds 512 bytes.
      assert (o_status == status_t'(last_sent << BYTES_PER_BLOCK_LOG2))
         else fail_value("status_bytes", last_sent << BYTES_PER_BLOCK_LOG2, int'(o_status));
      if (quiet_left > 0) begin
         assert (!o_rr_valid) else fail_value("holdoff_quiet", 0, 1);
         quiet_left--;
      end
      assert (pending <= MAX_OUTSTANDING)
         else fail_value("host_outstanding", MAX_OUTSTANDING, pending);
      // One partly read block can still sit in the FIFO behind the drain.
      assert (accepted - beats_read / BEATS_PER_BLOCK <= MAX_OUTSTANDING + 1)
         else fail_value("unread_blocks", MAX_OUTSTANDING + 1,
                         accepted - beats_read / BEATS_PER_BLOCK);
   endtask

   // Consumer with random stalls.
   task automatic drive_consumer();
      i_fifo_read = (next_random() % 4 != 0);
      if (i_fifo_read && o_fifo_valid) begin
         assert (o_fifo_data == beat_t'(beats_read))
            else fail_value("beat_order", beats_read, int'(o_fifo_data));
         beats_read++;
      end
   endtask

   // Host completions shuffled across blocks and beats.
   task automatic drive_completion();
      int          r;
      int          start;
      int          s;
      int          k;
      beat_index_t idx;
      logic [3:0]  nib;
      i_rc_valid = 1'b0;
      r = next_random() % 8;
      start = next_random() % BLOCK_COUNT;
      s = -1;
      for (int i = 0; i < BLOCK_COUNT; i++) begin
         if (s < 0 && slot_busy[(start + i) % BLOCK_COUNT]) s = (start + i) % BLOCK_COUNT;
      end
      if (r == 0) begin
         // Foreign channel beat.
         // Its nibble never equals CHANNEL_ID.
         nib = 4'(next_random() % 15);
         if (nib >= CHANNEL_ID) nib = nib + 4'd1;
         i_rc_valid = 1'b1;
         i_rc_tag = {nib, 4'(next_random())};
         i_rc_index = beat_index_t'(next_random());
         i_rc_data = {32'(next_random()), 32'(next_random())};
      end else if (r < 6 && s >= 0) begin
         if (rem_cnt[s] > 0) begin
            k = next_random() % rem_cnt[s];
            idx = rem_idx[s][k];
            rem_idx[s][k] = rem_idx[s][rem_cnt[s] - 1];
            rem_cnt[s]--;
         end else begin
            idx = beat_index_t'(BEATS_PER_BLOCK - 1);
            slot_busy[s] = 1'b0;
            last_sent++;
         end
         i_rc_valid = 1'b1;
         i_rc_tag = {CHANNEL_ID, 1'b0, block_ptr_t'(s)};
         i_rc_index = idx;
         i_rc_data = beat_t'(slot_seq[s] * BEATS_PER_BLOCK + int'(idx));
      end
   endtask

   // Host accepts requests at random with a one cycle strobe.
   task automatic drive_request();
      int slot;
      i_rr_ready = 1'b0;
      if (o_rr_valid && accepted < NUM_BLOCKS && next_random() % 2 == 0) begin
         slot = accepted % BLOCK_COUNT;
         assert (o_rr_tag_low == block_ptr_t'(slot))
            else fail_value("tag_order", slot, int'(o_rr_tag_low));
         assert (!slot_busy[slot]) else begin
            $display("Tag %0d was requested again before its beats were returned", slot);
            abort_run();
         end
         for (int i = 0; i < BEATS_PER_BLOCK - 1; i++) begin
            rem_idx[slot][i] = beat_index_t'(i);
         end
         rem_cnt[slot] = BEATS_PER_BLOCK - 1;
         slot_seq[slot] = accepted;
         slot_busy[slot] = 1'b1;
         i_rr_ready = 1'b1;
         quiet_left = HOLDOFF_CYCLES;
         accepted++;
      end
   endtask

   // Inputs change one unit after the edge.
   task automatic run_cycle();
      @(posedge clock);
      #1;
      check_outputs();
      drive_consumer();
      drive_completion();
      drive_request();
   endtask

   initial begin
      rng_state = 32'd12;
      reset = 1'b1;
      i_rr_ready = 1'b0;
      i_rc_valid = 1'b0;
      i_rc_tag = '0;
      i_rc_index = '0;
      i_rc_data = '0;
      i_fifo_read = 1'b0;
      accepted = 0;
      last_sent = 0;
      beats_read = 0;
      quiet_left = 0;
      cycles = 0;
      for (int s = 0; s < BLOCK_COUNT; s++) begin
         slot_busy[s] = 1'b0;
         slot_seq[s] = 0;
         rem_cnt[s] = 0;
      end
      repeat (16) @(posedge clock);
      #1;
      reset = 1'b0;
      @(posedge clock);
      #1;
      assert (!o_fifo_valid) else fail_value("reset_fifo_valid", 0, 1);
      assert (o_status == '0) else fail_value("reset_status", 0, int'(o_status));
      assert (o_rr_valid) else fail_value("reset_rr_valid", 1, 0);
      // Main traffic.
      while (beats_read < TOTAL_BEATS && cycles < RUN_LIMIT) begin
         run_cycle();
         cycles++;
      end
      if (beats_read < TOTAL_BEATS) begin
         $display("Timeout: only %0d of %0d beats came out", beats_read, TOTAL_BEATS);
         abort_run();
      end
      // Quiet tail with foreign beats only.
      // No extra output may appear.
      repeat (TAIL_CYCLES) run_cycle();
      if (beats_read == accepted * BEATS_PER_BLOCK && accepted == NUM_BLOCKS &&
          o_status == status_t'(accepted << BYTES_PER_BLOCK_LOG2) && !o_fifo_valid) begin
         $display("Everything OK");
         $finish;
      end else begin
         if (beats_read != accepted * BEATS_PER_BLOCK) begin
            fail_value("total_beats", accepted * BEATS_PER_BLOCK, beats_read);
         end else if (accepted != NUM_BLOCKS) begin
            fail_value("blocks_requested", NUM_BLOCKS, accepted);
         end else if (o_status != status_t'(accepted << BYTES_PER_BLOCK_LOG2)) begin
            fail_value("final_status", accepted << BYTES_PER_BLOCK_LOG2, int'(o_status));
         end else begin
            fail_value("fifo_drained", 0, 1);
         end
      end
   end

endmodule

// ==== host_read_channel.f ====
hifi_pkg.sv
block_ram.sv
read_request_scheduler.sv
completion_reorder.sv
reorder_drain.sv
fwft_fifo.sv
host_read_channel.sv
tb_host_read_channel.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the host read channel testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_host_read_channel

# Build the simulation binary.
verilator --binary --timing --assert --top-module "$TOP" -f host_read_channel.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Run and keep the transcript.
./obj_dir/V"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The transcript decides pass or fail.
if grep -q "Something failed" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi
echo "Simulation passed"
exit 0
